//--- Bender.yml
package:
  name: uart_periph

sources:
  - rtl/uart_pkg.sv
  - rtl/uart_baud_gen.sv
  - rtl/uart_tx.sv
  - rtl/uart_rx.sv
  - rtl/uart_regs.sv
  - rtl/uart_periph.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/uart_periph_tb.sv

//--- rtl/uart_baud_gen.sv
// ############################
// oversampling tick generator
// one pulse every clk_div clocks, shared by tx and rx
// ############################
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen (
   input  wire  clk,
   input  wire  reset,
   output logic tick
);

   logic [uart_pkg::div_w-1:0] div_cnt;  // free running

   always_ff @(posedge clk) begin
      if (reset) begin
         div_cnt <= '0;
         tick    <= 1'b0;
      end else begin
         // wrap at terminal count
         if (div_cnt == uart_pkg::div_last) begin
            div_cnt <= '0;
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
         tick <= (div_cnt == uart_pkg::div_last);  // registered pulse
      end
   end

endmodule

`default_nettype wire

//--- rtl/uart_periph.sv
// ############################
// uart peripheral top level
// one bus register word plus rxd and txd pins
// ############################
`timescale 1ns/1ps
`default_nettype none

module uart_periph (
   input  wire                 clk,
   input  wire                 reset,
   input  uart_pkg::bus_req_t  req,
   input  wire                 rxd,
   output logic [31:0]         rdata,
   output logic                txd
);

   logic               tick;      // shared oversampling tick
   logic               tx_start;
   logic [7:0]         tx_data;
   logic               tx_busy;
   uart_pkg::rx_byte_t rx_byte;

   uart_regs i_uart_regs (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .rdata    (rdata),
      .rx_byte  (rx_byte),
      .tx_busy  (tx_busy),
      .tx_start (tx_start),
      .tx_data  (tx_data)
   );

   uart_baud_gen i_uart_baud_gen (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

   uart_tx i_uart_tx (
      .clk      (clk),
      .reset    (reset),
      .tick     (tick),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .txd      (txd),
      .tx_busy  (tx_busy)
   );

   uart_rx i_uart_rx (
      .clk     (clk),
      .reset   (reset),
      .tick    (tick),
      .rxd     (rxd),
      .rx_byte (rx_byte)
   );

endmodule

`default_nettype wire

//--- rtl/uart_pkg.sv
// ############################
// shared constants and types for the uart peripheral
// bit timing, bus request, rx byte, fsm states
// referenced by scoped name, never imported
// ############################
`default_nettype none

package uart_pkg;

   // bit timing, 8N1 only
   localparam int clk_div    = 4;   // clocks per oversampling tick
   localparam int oversample = 16;  // ticks per serial bit
   localparam int mid_tick   = 7;   // sample point within a bit
   localparam int data_bits  = 8;

   // counter widths
   localparam int div_w  = $clog2(clk_div);
   localparam int tick_w = $clog2(oversample);
   localparam int bit_w  = $clog2(data_bits);

   // terminal counts sized to their counters
   localparam logic [div_w-1:0]  div_last  = div_w'(clk_div - 1);
   localparam logic [tick_w-1:0] tick_last = tick_w'(oversample - 1);
   localparam logic [tick_w-1:0] tick_mid  = tick_w'(mid_tick);
   localparam logic [bit_w-1:0]  bit_last  = bit_w'(data_bits - 1);

   // status word layout, byte sits in [7:0]
   localparam int stat_rx_valid_bit = 8;
   localparam int stat_tx_busy_bit  = 9;
   localparam int stat_overrun_bit  = 10;

   // cpu side request, strobes are single-cycle
   typedef struct packed {
      logic        sel;
      logic        rstrb;
      logic        wstrb;
      logic [31:0] wdata;
   } bus_req_t;

   // receiver to register block
   typedef struct packed {
      logic       valid;  // one-cycle strobe
      logic [7:0] data;   // good only while valid
   } rx_byte_t;

   typedef enum logic [1:0] {
      tx_idle,
      tx_start,
      tx_data,
      tx_stop
   } tx_state_e;

   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_e;

endpackage

`default_nettype wire

//--- rtl/uart_regs.sv
// ############################
// cpu facing register word
// read: byte and status, clears valid and overrun
// write: low byte goes out on txd unless busy
// ############################
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
   input  wire                 clk,
   input  wire                 reset,
   input  uart_pkg::bus_req_t  req,
   output logic [31:0]         rdata,
   input  uart_pkg::rx_byte_t  rx_byte,
   input  wire                 tx_busy,
   output logic                tx_start,
   output logic [7:0]          tx_data
);

   logic [7:0] rx_data;   // last byte received
   logic       rx_valid;  // unread byte present
   logic       overrun;   // sticky, byte lost
   logic       rd;
   logic       wr;

   // strobes only count while selected
   assign rd = req.sel && req.rstrb;
   assign wr = req.sel && req.wstrb;

   // writes during a frame are dropped
   assign tx_start = wr && !tx_busy;
   assign tx_data  = req.wdata[7:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         rx_data  <= '0;  // status word reads zero out of reset
         rx_valid <= 1'b0;
         overrun  <= 1'b0;
      end else begin
         if (rx_byte.valid) begin
            rx_data  <= rx_byte.data;
            rx_valid <= 1'b1;  // new byte wins over a read
            // old unread byte gets lost
            overrun  <= rx_valid;
         end else if (rd) begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
         end
      end
   end

   // status word reads zero when not selected
   always_comb begin
      rdata = '0;
      if (req.sel) begin
         rdata[7:0]                          = rx_data;
         rdata[uart_pkg::stat_rx_valid_bit] = rx_valid;
         rdata[uart_pkg::stat_tx_busy_bit]  = tx_busy;
         rdata[uart_pkg::stat_overrun_bit]  = overrun;
      end
   end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
// ############################
// 8N1 receiver
// start detect on a tick, mid-bit sampling, stop bit check
// bytes with a low stop bit are dropped without notice
// ############################
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  wire                 clk,
   input  wire                 reset,
   input  wire                 tick,
   input  wire                 rxd,
   output uart_pkg::rx_byte_t  rx_byte
);

   uart_pkg::rx_state_e         state;
   logic                        rxd_meta;   // first sync stage
   logic                        rxd_sync;   // safe to use
   logic [uart_pkg::tick_w-1:0] tick_cnt;   // index of the next tick in this bit
   logic [uart_pkg::bit_w-1:0]  bit_cnt;
   logic [7:0]                  shift_reg;
   logic                        valid_q;
   logic                        mid_pt;
   logic                        bit_end;

   assign mid_pt  = tick && (tick_cnt == uart_pkg::tick_mid);
   assign bit_end = tick && (tick_cnt == uart_pkg::tick_last);

   assign rx_byte = '{valid: valid_q, data: shift_reg};

   // two-flop synchronizer, reset high so no false start
   always_ff @(posedge clk) begin
      if (reset) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= uart_pkg::rx_idle;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         valid_q  <= 1'b0;
      end else begin
         valid_q <= 1'b0;  // strobe by default
         if (tick && state != uart_pkg::rx_idle) begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
         end
         case (state)
            uart_pkg::rx_idle: begin
               if (tick && !rxd_sync) begin
                  state    <= uart_pkg::rx_start;
                  tick_cnt <= {{(uart_pkg::tick_w-1){1'b0}}, 1'b1};  // this tick was index 0
                  bit_cnt  <= '0;
               end
            end
            uart_pkg::rx_start: begin
               if (mid_pt && rxd_sync) begin
                  state <= uart_pkg::rx_idle;  // glitch, not a start bit
               end else if (bit_end) begin
                  state <= uart_pkg::rx_data;
               end
            end
            uart_pkg::rx_data: begin
               if (bit_end) begin
                  if (bit_cnt == uart_pkg::bit_last) begin
                     state <= uart_pkg::rx_stop;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            uart_pkg::rx_stop: begin
               if (mid_pt) begin
                  state   <= uart_pkg::rx_idle;  // rearm early for the next start
                  valid_q <= rxd_sync;           // framing error drops the byte
               end
            end
            default: state <= uart_pkg::rx_idle;
         endcase
      end
   end

   // data bits come in lsb first, shift toward bit 0
   always_ff @(posedge clk) begin
      if (state == uart_pkg::rx_data && mid_pt) begin
         shift_reg <= {rxd_sync, shift_reg[7:1]};
      end
   end

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
// ############################
// 8N1 serializer
// pulse tx_start while idle to send tx_data, lsb first
// tx_busy stays high until the stop bit is done
// ############################
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  wire        clk,
   input  wire        reset,
   input  wire        tick,
   input  wire        tx_start,
   input  wire  [7:0] tx_data,
   output logic       txd,
   output logic       tx_busy
);

   uart_pkg::tx_state_e         state;
   logic [uart_pkg::tick_w-1:0] tick_cnt;   // ticks within current bit
   logic [uart_pkg::bit_w-1:0]  bit_cnt;    // data bit index
   logic [7:0]                  shift_reg;  // outgoing byte
   logic                        bit_end;
   logic                        launch;

   assign launch  = (state == uart_pkg::tx_idle) && tx_start;
   assign bit_end = tick && (tick_cnt == uart_pkg::tick_last);  // last tick of a bit
   assign tx_busy = (state != uart_pkg::tx_idle);

   // control fsm
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= uart_pkg::tx_idle;
         txd      <= 1'b1;  // line idles high
         tick_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         if (tick && state != uart_pkg::tx_idle) begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
         end
         case (state)
            uart_pkg::tx_idle: begin
               if (tx_start) begin
                  state    <= uart_pkg::tx_start;
                  txd      <= 1'b0;  // start bit
                  tick_cnt <= '0;
                  bit_cnt  <= '0;
               end
            end
            uart_pkg::tx_start: begin
               if (bit_end) begin
                  state <= uart_pkg::tx_data;
                  txd   <= shift_reg[0];  // bit 0 goes first
               end
            end
            uart_pkg::tx_data: begin
               if (bit_end) begin
                  if (bit_cnt == uart_pkg::bit_last) begin
                     state <= uart_pkg::tx_stop;
                     txd   <= 1'b1;  // stop bit
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                     txd     <= shift_reg[0];  // already shifted
                  end
               end
            end
            uart_pkg::tx_stop: begin
               if (bit_end) begin
                  state <= uart_pkg::tx_idle;  // busy drops next edge
               end
            end
            default: state <= uart_pkg::tx_idle;
         endcase
      end
   end

   // shift path, load on launch then shift once per bit
   always_ff @(posedge clk) begin
      if (launch) begin
         shift_reg <= tx_data;
      end else if (bit_end && (state == uart_pkg::tx_start || state == uart_pkg::tx_data)) begin
         shift_reg <= {1'b0, shift_reg[7:1]};
      end
   end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// ############################
// testbench clock and reset
// 100 ns clock, reset high for the first 10 cycles
// ############################
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;  // 100 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (10) @(posedge clk);
      reset <= 1'b0;  // released on an edge, sync reset
   end

endmodule

`default_nettype wire

//--- sim/uart_periph_tb.sv
// ############################
// testbench for the uart peripheral
// drives the bus word and rxd, decodes txd, checks status
// ############################
`timescale 1ns/1ps
`default_nettype none

module uart_periph_tb;

   localparam int bit_clks = uart_pkg::clk_div * uart_pkg::oversample;  // 64 clocks
   localparam int half_bit = bit_clks / 2;
   localparam int rx_bit   = uart_pkg::stat_rx_valid_bit;
   localparam int busy_bit = uart_pkg::stat_tx_busy_bit;
   localparam int ovr_bit  = uart_pkg::stat_overrun_bit;

   logic               clk;
   logic               reset;
   uart_pkg::bus_req_t req;
   logic               rxd;
   logic [31:0]        rdata;
   logic               txd;
   logic [31:0]        stat;
   logic [7:0]         b1;
   logic [7:0]         b2;
   logic [7:0]         got;
   int                 cnt;

   tb_clock i_tb_clock (.clk(clk), .reset(reset));

   uart_periph i_uart_periph (
      .clk   (clk),
      .reset (reset),
      .req   (req),
      .rxd   (rxd),
      .rdata (rdata),
      .txd   (txd)
   );

   task automatic fail_run();
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic flag_mismatch(input string msg);
      $display("FAILED at %0t: %s", $time, msg);
      fail_run();
   endtask

   task automatic give_up_waiting(input string what, input int limit);
      $display("Timeout: %s did not happen within %0d clocks", what, limit);
      fail_run();
   endtask

   function automatic uart_pkg::bus_req_t make_req(input logic sel, input logic rstrb,
                                                   input logic wstrb, input logic [7:0] d);
      make_req = '{sel: sel, rstrb: rstrb, wstrb: wstrb, wdata: {24'h0, d}};
   endfunction

   // one-cycle write strobe then busy must read high in the following cycle
   task automatic write_byte(input logic [7:0] d);
      @(posedge clk) req <= make_req(1'b1, 1'b0, 1'b1, d);
      @(posedge clk) req <= make_req(1'b1, 1'b0, 1'b0, 8'h0);
      @(negedge clk);
      assert (rdata[busy_bit] === 1'b1) else flag_mismatch("tx_busy low after write");
      @(posedge clk) req <= '0;
   endtask

   task automatic read_status(output logic [31:0] s);
      @(posedge clk) req <= make_req(1'b1, 1'b0, 1'b0, 8'h0);
      @(negedge clk) s = rdata;
      @(posedge clk) req <= '0;
   endtask

   // read with strobe so flags clear on the closing edge
   task automatic read_clear(output logic [31:0] s);
      @(posedge clk) req <= make_req(1'b1, 1'b1, 1'b0, 8'h0);
      @(negedge clk) s = rdata;
      @(posedge clk) req <= '0;
   endtask

   // hold sel and poll one status bit
   task automatic poll_status(input int idx, input logic val, input int limit,
                              input string what, output logic [31:0] s);
      int n;
      n = 0;
      @(posedge clk) req <= make_req(1'b1, 1'b0, 1'b0, 8'h0);
      @(negedge clk) s = rdata;
      while (s[idx] !== val) begin
         if (n == limit) give_up_waiting(what, limit);
         n++;
         @(negedge clk) s = rdata;
      end
      @(posedge clk) req <= '0;
   endtask

   // start, 8 data bits lsb first, chosen stop level, then idle high
   task automatic send_frame(input logic [7:0] d, input logic stop);
      logic [9:0] frame;
      frame = {stop, d, 1'b0};
      @(posedge clk) rxd <= frame[0];
      for (int i = 1; i < 10; i++) begin
         repeat (bit_clks) @(posedge clk);
         rxd <= frame[i];
      end
      repeat (bit_clks) @(posedge clk);
      rxd <= 1'b1;
   endtask

   // returns at mid stop bit
   task automatic decode_frame(output logic [7:0] d);
      int n;
      n = 0;
      @(negedge clk);
      while (txd !== 1'b0) begin
         if (n == 4 * bit_clks) give_up_waiting("start bit on txd", 4 * bit_clks);
         n++;
         @(negedge clk);
      end
      repeat (half_bit) @(negedge clk);
      assert (txd === 1'b0) else flag_mismatch("start bit not low at mid-bit");
      for (int i = 0; i < 8; i++) begin
         repeat (bit_clks) @(negedge clk);
         d[i] = txd;
      end
      repeat (bit_clks) @(negedge clk);
      assert (txd === 1'b1) else flag_mismatch("stop bit on txd is low");
   endtask

   initial begin
      req = '0;
      rxd = 1'b1;  // idle line
      cnt = 0;
      void'($urandom(32'h845ce72c));
      @(negedge clk);
      while (reset !== 1'b0) begin
         if (cnt == 20) give_up_waiting("reset release", 20);
         cnt++;
         @(negedge clk);
      end

      // reset state
      assert (txd === 1'b1) else flag_mismatch("txd not high after reset");
      assert (rdata === 32'h0) else flag_mismatch("rdata nonzero with sel low");
      read_status(stat);
      assert (stat === 32'h0) else flag_mismatch($sformatf("status %h after reset", stat));

      // transmit one byte
      b1 = 8'($urandom);
      fork
         decode_frame(got);
         write_byte(b1);
      join
      assert (got === b1) else flag_mismatch($sformatf("tx sent %h, expected %h", got, b1));
      poll_status(busy_bit, 1'b0, bit_clks, "tx_busy falling", stat);

      // second write during a frame is dropped
      b1 = 8'($urandom);
      b2 = 8'($urandom);
      if (b2 == b1) b2 = ~b1;
      fork
         decode_frame(got);
         begin
            write_byte(b1);
            write_byte(b2);  // busy reads high here
         end
      join
      assert (got === b1) else flag_mismatch($sformatf("tx sent %h, expected %h", got, b1));
      repeat (half_bit + 2 * bit_clks) begin
         @(negedge clk);
         assert (txd === 1'b1) else flag_mismatch("dropped write started a frame");
      end

      // receive, then clear on read
      b1 = 8'($urandom);
      fork
         send_frame(b1, 1'b1);
         poll_status(rx_bit, 1'b1, 12 * bit_clks, "rx_valid after good frame", stat);
      join
      assert (stat[7:0] === b1) else flag_mismatch($sformatf("rx %h, expected %h", stat[7:0], b1));
      assert (stat[ovr_bit] === 1'b0) else flag_mismatch("overrun set on single byte");
      @(negedge clk);  // byte waiting, sel low
      assert (rdata === 32'h0) else flag_mismatch("rdata nonzero with sel low and byte waiting");
      read_clear(stat);
      read_status(stat);
      assert (stat[rx_bit] === 1'b0) else flag_mismatch("rx_valid not cleared by read");

      // two bytes with no read between
      b1 = 8'($urandom);
      b2 = 8'($urandom);
      if (b2 == b1) b2 = ~b1;
      send_frame(b1, 1'b1);
      send_frame(b2, 1'b1);
      poll_status(ovr_bit, 1'b1, 4 * bit_clks, "overrun flag", stat);
      assert (stat[rx_bit] === 1'b1) else flag_mismatch("rx_valid clear on overrun");
      assert (stat[7:0] === b2) else flag_mismatch($sformatf("rx %h, expected %h", stat[7:0], b2));
      read_clear(stat);
      read_status(stat);
      assert (stat[rx_bit] === 1'b0 && stat[ovr_bit] === 1'b0)
         else flag_mismatch($sformatf("flags not cleared, status %h", stat));

      // low stop bit drops the frame
      send_frame(8'($urandom), 1'b0);
      repeat (2 * bit_clks) @(negedge clk);
      read_status(stat);
      assert (stat[rx_bit] === 1'b0) else flag_mismatch("frame with low stop bit accepted");
      // the rx may take the low stop as a new start and run out that frame
      repeat (11 * bit_clks) @(posedge clk);
      read_clear(stat);  // drop it
      b2 = 8'($urandom);
      fork
         send_frame(b2, 1'b1);
         poll_status(rx_bit, 1'b1, 12 * bit_clks, "rx_valid after bad stop bit", stat);
      join
      assert (stat[7:0] === b2) else flag_mismatch($sformatf("rx %h, expected %h", stat[7:0], b2));

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- uart_periph.f
rtl/uart_pkg.sv
rtl/uart_baud_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_regs.sv
rtl/uart_periph.sv
sim/tb_clock.sv
sim/uart_periph_tb.sv
